// File: logic/cache_pkg.sv
// cache geometry and line types, referenced by scoped name from rtl and testbench
`default_nettype none

package cache_pkg;

	// geometry
	localparam int num_sets = 8;
	localparam int num_ways = 4;
	localparam int set_bits = $clog2(num_sets);
	localparam int way_bits = $clog2(num_ways);
	localparam int tag_bits = 8;
	localparam int data_bits = 64;

	// binary tree, one node per internal branch
	localparam int tree_bits = num_ways - 1;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [tag_bits-1:0] tag;
		logic [data_bits-1:0] data;
	} cache_line_t;

	// way 0 sits in the low bits
	typedef cache_line_t [num_ways-1:0] cache_set_t;

endpackage

`default_nettype wire

// File: logic/tag_lookup_if.sv
// one tag lookup between the cache store and a matcher; store requests, matcher answers
`timescale 1ns/1ps
`default_nettype none

interface tag_lookup_if;

	logic en;
	logic [cache_pkg::tag_bits-1:0] tag;
	cache_pkg::cache_set_t set_lines;
	logic hit;
	logic [cache_pkg::way_bits-1:0] way;

	modport requester (
		output en,
		output tag,
		output set_lines,
		input hit,
		input way
	);

	modport matcher (
		input en,
		input tag,
		input set_lines,
		output hit,
		output way
	);

endinterface

`default_nettype wire

// File: logic/way_match.sv
// parallel tag compare over one set, giving a hit flag and the lowest matching way
`timescale 1ns/1ps
`default_nettype none

module way_match (
	tag_lookup_if.matcher lookup
);

	logic [cache_pkg::num_ways-1:0] match;

	// only valid ways count, and nothing matches while idle
	always_comb begin
		for (int i = 0; i < cache_pkg::num_ways; i++) begin
			match[i] = lookup.en & lookup.set_lines[i].valid &
				(lookup.set_lines[i].tag == lookup.tag);
		end
	end

	assign lookup.hit = |match;

	// priority to the lowest way
	always_comb begin
		lookup.way = '0;
		for (int i = cache_pkg::num_ways - 1; i >= 0; i--) begin
			if (match[i]) begin
				lookup.way = cache_pkg::way_bits'(i);
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/plru_tree.sv
// tree pseudo-lru for one set: next tree after an access, and the current victim way
`timescale 1ns/1ps
`default_nettype none

module plru_tree (
	input logic [cache_pkg::tree_bits-1:0] tree_in,
	input logic [cache_pkg::way_bits-1:0] access_way,
	output logic [cache_pkg::tree_bits-1:0] tree_out,
	output logic [cache_pkg::way_bits-1:0] victim_way
);

	// node n has children 2n+1 (left, low ways) and 2n+2 (right)
	// node value 0 sends the victim left, 1 sends it right

	always_comb begin : update
		int node;
		tree_out = tree_in;
		node = 0;
		// walk from the root, msb of the way picks the branch
		for (int lvl = cache_pkg::way_bits - 1; lvl >= 0; lvl--) begin
			// point away from the half just used
			tree_out[node] = ~access_way[lvl];
			node = 2 * node + 1 + int'(access_way[lvl]);
		end
	end

	always_comb begin : select
		int node;
		victim_way = '0;
		node = 0;
		for (int lvl = cache_pkg::way_bits - 1; lvl >= 0; lvl--) begin
			victim_way[lvl] = tree_in[node];
			node = 2 * node + 1 + int'(tree_in[node]);
		end
	end

endmodule

`default_nettype wire

// File: logic/cachemem.sv
// set-associative cache store, two combinational read ports, one write port with plru allocation
`timescale 1ns/1ps
`default_nettype none

module cachemem (
	input logic clock,
	input logic reset,
	input logic wr_en,
	input logic rd1_en,
	input logic rd2_en,
	input logic [cache_pkg::set_bits-1:0] wr_idx,
	input logic [cache_pkg::set_bits-1:0] rd1_idx,
	input logic [cache_pkg::set_bits-1:0] rd2_idx,
	input logic [cache_pkg::tag_bits-1:0] wr_tag,
	input logic [cache_pkg::tag_bits-1:0] rd1_tag,
	input logic [cache_pkg::tag_bits-1:0] rd2_tag,
	input logic [cache_pkg::data_bits-1:0] wr_data,
	input logic wr_dirty,

	output logic [cache_pkg::data_bits-1:0] rd1_data,
	output logic [cache_pkg::data_bits-1:0] rd2_data,
	output logic rd1_valid,
	output logic rd2_valid,

	output logic miss_valid_rd1,
	output logic miss_valid_rd2,
	output logic miss_valid_wr,
	output logic [cache_pkg::set_bits-1:0] miss_idx_rd1,
	output logic [cache_pkg::set_bits-1:0] miss_idx_rd2,
	output logic [cache_pkg::set_bits-1:0] miss_idx_wr,
	output logic [cache_pkg::tag_bits-1:0] miss_tag_rd1,
	output logic [cache_pkg::tag_bits-1:0] miss_tag_rd2,
	output logic [cache_pkg::tag_bits-1:0] miss_tag_wr,

	output logic victim_valid,
	output cache_pkg::cache_line_t victim,
	output logic [cache_pkg::set_bits-1:0] victim_idx
);

	cache_pkg::cache_set_t [cache_pkg::num_sets-1:0] sets;
	cache_pkg::cache_set_t [cache_pkg::num_sets-1:0] sets_next;

	// tree state, plus the result after each update in the chain
	logic [cache_pkg::num_sets-1:0][cache_pkg::tree_bits-1:0] tree;
	logic [cache_pkg::num_sets-1:0][cache_pkg::tree_bits-1:0] tree_wr;
	logic [cache_pkg::num_sets-1:0][cache_pkg::tree_bits-1:0] tree_rd1;
	logic [cache_pkg::num_sets-1:0][cache_pkg::tree_bits-1:0] tree_next;

	logic [cache_pkg::tree_bits-1:0] wr_tree_out;
	logic [cache_pkg::tree_bits-1:0] rd1_tree_out;
	logic [cache_pkg::tree_bits-1:0] rd2_tree_out;

	logic [cache_pkg::way_bits-1:0] plru_way;
	logic [cache_pkg::way_bits-1:0] invalid_way;
	logic has_invalid;
	logic [cache_pkg::way_bits-1:0] wr_way;

	logic rd1_fwd;
	logic rd2_fwd;
	logic [cache_pkg::way_bits-1:0] rd1_way;
	logic [cache_pkg::way_bits-1:0] rd2_way;

	tag_lookup_if rd1_lookup ();
	tag_lookup_if rd2_lookup ();
	tag_lookup_if wr_lookup ();

	assign rd1_lookup.en = rd1_en;
	assign rd1_lookup.tag = rd1_tag;
	assign rd1_lookup.set_lines = sets[rd1_idx];

	assign rd2_lookup.en = rd2_en;
	assign rd2_lookup.tag = rd2_tag;
	assign rd2_lookup.set_lines = sets[rd2_idx];

	assign wr_lookup.en = wr_en;
	assign wr_lookup.tag = wr_tag;
	assign wr_lookup.set_lines = sets[wr_idx];

	way_match rd1_match (.lookup(rd1_lookup));
	way_match rd2_match (.lookup(rd2_lookup));
	way_match wr_match (.lookup(wr_lookup));

	// lowest invalid way in the write set
	always_comb begin
		has_invalid = 1'b0;
		invalid_way = '0;
		for (int i = cache_pkg::num_ways - 1; i >= 0; i--) begin
			if (!sets[wr_idx][i].valid) begin
				has_invalid = 1'b1;
				invalid_way = cache_pkg::way_bits'(i);
			end
		end
	end

	// only the victim pointer is needed here
	plru_tree victim_plru (
		.tree_in(tree[wr_idx]),
		.access_way('0),
		.tree_out(),
		.victim_way(plru_way)
	);

	always_comb begin
		if (wr_lookup.hit) begin
			wr_way = wr_lookup.way;
		end else if (has_invalid) begin
			wr_way = invalid_way;
		end else begin
			wr_way = plru_way;
		end
	end

	assign victim_valid = wr_en & ~wr_lookup.hit & ~has_invalid;
	assign victim = sets[wr_idx][wr_way];
	assign victim_idx = wr_idx;

	assign miss_valid_wr = wr_en & ~wr_lookup.hit;
	assign miss_idx_wr = wr_idx;
	assign miss_tag_wr = wr_tag;

	// same-cycle write to the same line wins over the stored copy
	assign rd1_fwd = rd1_en & wr_en & (wr_idx == rd1_idx) & (wr_tag == rd1_tag);
	assign rd2_fwd = rd2_en & wr_en & (wr_idx == rd2_idx) & (wr_tag == rd2_tag);

	assign rd1_data = rd1_fwd ? wr_data : sets[rd1_idx][rd1_lookup.way].data;
	assign rd2_data = rd2_fwd ? wr_data : sets[rd2_idx][rd2_lookup.way].data;
	assign rd1_valid = rd1_fwd | rd1_lookup.hit;
	assign rd2_valid = rd2_fwd | rd2_lookup.hit;

	assign miss_valid_rd1 = rd1_en & ~rd1_valid;
	assign miss_idx_rd1 = rd1_idx;
	assign miss_tag_rd1 = rd1_tag;
	assign miss_valid_rd2 = rd2_en & ~rd2_valid;
	assign miss_idx_rd2 = rd2_idx;
	assign miss_tag_rd2 = rd2_tag;

	// a forwarded read touches the way the write lands in
	assign rd1_way = rd1_fwd ? wr_way : rd1_lookup.way;
	assign rd2_way = rd2_fwd ? wr_way : rd2_lookup.way;

	// plru chain: write, then rd1, then rd2
	plru_tree wr_plru (
		.tree_in(tree[wr_idx]),
		.access_way(wr_way),
		.tree_out(wr_tree_out),
		.victim_way()
	);

	always_comb begin
		tree_wr = tree;
		if (wr_en) begin
			tree_wr[wr_idx] = wr_tree_out;
		end
	end

	plru_tree rd1_plru (
		.tree_in(tree_wr[rd1_idx]),
		.access_way(rd1_way),
		.tree_out(rd1_tree_out),
		.victim_way()
	);

	always_comb begin
		tree_rd1 = tree_wr;
		if (rd1_valid) begin
			tree_rd1[rd1_idx] = rd1_tree_out;
		end
	end

	plru_tree rd2_plru (
		.tree_in(tree_rd1[rd2_idx]),
		.access_way(rd2_way),
		.tree_out(rd2_tree_out),
		.victim_way()
	);

	always_comb begin
		tree_next = tree_rd1;
		if (rd2_valid) begin
			tree_next[rd2_idx] = rd2_tree_out;
		end
	end

	always_comb begin
		sets_next = sets;
		if (wr_en) begin
			sets_next[wr_idx][wr_way].valid = 1'b1;
			sets_next[wr_idx][wr_way].dirty = wr_dirty;
			sets_next[wr_idx][wr_way].tag = wr_tag;
			sets_next[wr_idx][wr_way].data = wr_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			sets <= '0;
			tree <= '0;
		end else begin
			sets <= sets_next;
			tree <= tree_next;
		end
	end

endmodule

`default_nettype wire

// File: tb/clock_gen.sv
// testbench clock and reset source; instantiate once in the testbench top
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clock,
	output logic reset
);

	localparam int period = 100;
	localparam int reset_cycles = 3;

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// reset spans the first rising edges, dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb/cachemem_tb.sv
// simulation top that runs directed tests of the cache store against a reference model
`timescale 1ns/1ps
`default_nettype none

module cachemem_tb;

	localparam int sample_delay = 40;

	logic clock, reset;
	logic wr_en, rd1_en, rd2_en, wr_dirty;
	logic [cache_pkg::set_bits-1:0] wr_idx, rd1_idx, rd2_idx;
	logic [cache_pkg::tag_bits-1:0] wr_tag, rd1_tag, rd2_tag;
	logic [cache_pkg::data_bits-1:0] wr_data, rd1_data, rd2_data;
	logic rd1_valid, rd2_valid, miss_valid_rd1, miss_valid_rd2, miss_valid_wr;
	logic [cache_pkg::set_bits-1:0] miss_idx_rd1, miss_idx_rd2, miss_idx_wr, victim_idx;
	logic [cache_pkg::tag_bits-1:0] miss_tag_rd1, miss_tag_rd2, miss_tag_wr;
	logic victim_valid;
	cache_pkg::cache_line_t victim;

	// model of the line array and the tree bits
	cache_pkg::cache_line_t model_lines [cache_pkg::num_sets][cache_pkg::num_ways];
	logic [cache_pkg::tree_bits-1:0] model_tree [cache_pkg::num_sets];

	// outputs seen in the last cycle
	logic got_rd1_valid, got_victim_valid, got_miss_wr;
	logic [cache_pkg::data_bits-1:0] got_rd1_data;
	cache_pkg::cache_line_t got_victim;

	clock_gen clocks (.clock(clock), .reset(reset));

	cachemem DUT (
		.clock(clock), .reset(reset),
		.wr_en(wr_en), .rd1_en(rd1_en), .rd2_en(rd2_en),
		.wr_idx(wr_idx), .rd1_idx(rd1_idx), .rd2_idx(rd2_idx),
		.wr_tag(wr_tag), .rd1_tag(rd1_tag), .rd2_tag(rd2_tag),
		.wr_data(wr_data), .wr_dirty(wr_dirty),
		.rd1_data(rd1_data), .rd2_data(rd2_data),
		.rd1_valid(rd1_valid), .rd2_valid(rd2_valid),
		.miss_valid_rd1(miss_valid_rd1), .miss_valid_rd2(miss_valid_rd2),
		.miss_valid_wr(miss_valid_wr),
		.miss_idx_rd1(miss_idx_rd1), .miss_idx_rd2(miss_idx_rd2), .miss_idx_wr(miss_idx_wr),
		.miss_tag_rd1(miss_tag_rd1), .miss_tag_rd2(miss_tag_rd2), .miss_tag_wr(miss_tag_wr),
		.victim_valid(victim_valid), .victim(victim), .victim_idx(victim_idx)
	);

	task automatic check(input logic [127:0] actual, input logic [127:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s: got %0h, expected %0h", $time, what, actual,
				expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// follow the node values down from the root
	function automatic logic [cache_pkg::way_bits-1:0] victim_of_tree(
			logic [cache_pkg::tree_bits-1:0] t);
		int lo, hi, node;
		lo = 0;
		hi = cache_pkg::num_ways;
		node = 0;
		while (hi - lo > 1) begin
			if (t[node]) begin
				lo = (lo + hi) / 2;
				node = 2 * node + 2;
			end else begin
				hi = (lo + hi) / 2;
				node = 2 * node + 1;
			end
		end
		return cache_pkg::way_bits'(lo);
	endfunction

	// every node on the path points away from way w
	function automatic logic [cache_pkg::tree_bits-1:0] touch_tree(
			logic [cache_pkg::tree_bits-1:0] t, int w);
		int lo, hi, mid, node;
		logic [cache_pkg::tree_bits-1:0] r;
		r = t;
		lo = 0;
		hi = cache_pkg::num_ways;
		node = 0;
		while (hi - lo > 1) begin
			mid = (lo + hi) / 2;
			r[node] = (w < mid);
			if (w < mid) begin
				hi = mid;
				node = 2 * node + 1;
			end else begin
				lo = mid;
				node = 2 * node + 2;
			end
		end
		return r;
	endfunction

	// lowest valid way holding the tag or -1
	function automatic int find_way(int idx, logic [cache_pkg::tag_bits-1:0] tag);
		for (int w = 0; w < cache_pkg::num_ways; w++) begin
			if (model_lines[idx][w].valid && model_lines[idx][w].tag == tag) begin
				return w;
			end
		end
		return -1;
	endfunction

	task automatic idle();
		wr_en = 1'b0;
		rd1_en = 1'b0;
		rd2_en = 1'b0;
		wr_dirty = 1'b0;
		wr_idx = '0;
		rd1_idx = '0;
		rd2_idx = '0;
		wr_tag = '0;
		rd1_tag = '0;
		rd2_tag = '0;
		wr_data = '0;
	endtask

	task automatic start_write(int idx, int tag, logic [cache_pkg::data_bits-1:0] data,
			logic dirty);
		wr_en = 1'b1;
		wr_idx = cache_pkg::set_bits'(idx);
		wr_tag = cache_pkg::tag_bits'(tag);
		wr_data = data;
		wr_dirty = dirty;
	endtask

	// port 1 drives rd1, any other value drives rd2
	task automatic request_read(int port, int idx, int tag);
		if (port == 1) begin
			rd1_en = 1'b1;
			rd1_idx = cache_pkg::set_bits'(idx);
			rd1_tag = cache_pkg::tag_bits'(tag);
		end else begin
			rd2_en = 1'b1;
			rd2_idx = cache_pkg::set_bits'(idx);
			rd2_tag = cache_pkg::tag_bits'(tag);
		end
	endtask

	function automatic logic [cache_pkg::data_bits-1:0] random_data();
		return {$urandom, $urandom};
	endfunction

	// predict, sample before the rising edge, compare, then advance the model
	task automatic run_cycle();
		int wh, wway, h1, h2;
		logic f1, f2, v1, v2, exp_vv;
		cache_pkg::cache_line_t exp_victim;
		wh = find_way(wr_idx, wr_tag);
		wway = wh;
		if (wh < 0) begin
			for (int w = cache_pkg::num_ways - 1; w >= 0; w--) begin
				if (!model_lines[wr_idx][w].valid) wway = w;
			end
			if (wway < 0) wway = victim_of_tree(model_tree[wr_idx]);
		end
		exp_vv = wr_en && wh < 0 && model_lines[wr_idx][wway].valid;
		exp_victim = model_lines[wr_idx][wway];
		h1 = find_way(rd1_idx, rd1_tag);
		h2 = find_way(rd2_idx, rd2_tag);
		f1 = rd1_en && wr_en && wr_idx == rd1_idx && wr_tag == rd1_tag;
		f2 = rd2_en && wr_en && wr_idx == rd2_idx && wr_tag == rd2_tag;
		v1 = f1 || (rd1_en && h1 >= 0);
		v2 = f2 || (rd2_en && h2 >= 0);
		#(sample_delay);
		check(rd1_valid, v1, "rd1_valid");
		check(rd2_valid, v2, "rd2_valid");
		if (v1) check(rd1_data, f1 ? wr_data : model_lines[rd1_idx][h1].data, "rd1_data");
		if (v2) check(rd2_data, f2 ? wr_data : model_lines[rd2_idx][h2].data, "rd2_data");
		check(miss_valid_rd1, rd1_en && !v1, "miss_valid_rd1");
		check(miss_valid_rd2, rd2_en && !v2, "miss_valid_rd2");
		check(miss_valid_wr, wr_en && wh < 0, "miss_valid_wr");
		if (rd1_en) check({miss_idx_rd1, miss_tag_rd1}, {rd1_idx, rd1_tag}, "rd1 miss address");
		if (rd2_en) check({miss_idx_rd2, miss_tag_rd2}, {rd2_idx, rd2_tag}, "rd2 miss address");
		if (wr_en) check({miss_idx_wr, miss_tag_wr}, {wr_idx, wr_tag}, "wr miss address");
		check(victim_valid, exp_vv, "victim_valid");
		if (exp_vv) begin
			check(victim, exp_victim, "victim line");
			check(victim_idx, wr_idx, "victim_idx");
		end
		got_rd1_valid = rd1_valid;
		got_rd1_data = rd1_data;
		got_victim_valid = victim_valid;
		got_victim = victim;
		got_miss_wr = miss_valid_wr;
		// write first, then rd1, then rd2
		if (wr_en) model_tree[wr_idx] = touch_tree(model_tree[wr_idx], wway);
		if (v1) model_tree[rd1_idx] = touch_tree(model_tree[rd1_idx], f1 ? wway : h1);
		if (v2) model_tree[rd2_idx] = touch_tree(model_tree[rd2_idx], f2 ? wway : h2);
		if (wr_en) model_lines[wr_idx][wway] = '{1'b1, wr_dirty, wr_tag, wr_data};
		@(negedge clock);
		idle();
	endtask

	task automatic fill_set(int idx, int first_tag);
		for (int w = 0; w < cache_pkg::num_ways; w++) begin
			start_write(idx, first_tag + w, random_data(), w[0]);
			run_cycle();
		end
	endtask

	task automatic test_reset_empty();
		for (int s = 0; s < 4; s++) begin
			request_read(1, s, 8'h10 + s);
			request_read(2, s + 4, 8'h20 + s);
			run_cycle();
			check(got_rd1_valid, 1'b0, "read after reset");
		end
	endtask

	task automatic test_write_then_read();
		for (int w = 0; w < cache_pkg::num_ways; w++) begin
			start_write(2, 8'h40 + w, random_data(), 1'b0);
			run_cycle();
			check(got_victim_valid, 1'b0, "victim on first fill");
		end
		for (int w = 0; w < cache_pkg::num_ways; w += 2) begin
			request_read(1, 2, 8'h40 + w);
			request_read(2, 2, 8'h41 + w);
			run_cycle();
			check(got_rd1_valid, 1'b1, "read back of written tag");
		end
	endtask

	task automatic test_forwarding();
		logic [cache_pkg::data_bits-1:0] d;
		d = random_data();
		start_write(6, 8'h77, d, 1'b1);
		request_read(1, 6, 8'h77);
		request_read(2, 6, 8'h77);
		run_cycle();
		check(got_rd1_data, d, "forwarded data");
		request_read(1, 6, 8'h77);
		run_cycle();
		check(got_rd1_valid, 1'b1, "hit after forwarded write");
	endtask

	task automatic test_eviction();
		fill_set(3, 8'h30);
		start_write(3, 8'h34, random_data(), 1'b0);
		run_cycle();
		check(got_victim_valid, 1'b1, "eviction on full set");
		request_read(1, 3, got_victim.tag);
		run_cycle();
		check(got_rd1_valid, 1'b0, "read of evicted tag");
	endtask

	// write and rd1 both land in the left half, so their order picks the victim
	task automatic test_read_updates_plru();
		fill_set(5, 8'h50);
		start_write(5, 8'h50, random_data(), 1'b0);
		request_read(1, 5, 8'h51);
		request_read(2, 5, 8'h52);
		run_cycle();
		start_write(5, 8'h5f, random_data(), 1'b1);
		run_cycle();
		check(got_victim_valid, 1'b1, "eviction after read hits");
	endtask

	task automatic test_write_hit_update();
		logic [cache_pkg::data_bits-1:0] d;
		d = random_data();
		start_write(2, 8'h41, d, 1'b1);
		run_cycle();
		check(got_miss_wr, 1'b0, "write hit miss flag");
		check(got_victim_valid, 1'b0, "write hit victim");
		request_read(1, 2, 8'h41);
		run_cycle();
		check(got_rd1_data, d, "data after write hit");
	endtask

	initial begin
		void'($urandom(32'heae0_b0a6));
		idle();
		for (int s = 0; s < cache_pkg::num_sets; s++) begin
			model_tree[s] = '0;
			for (int w = 0; w < cache_pkg::num_ways; w++) model_lines[s][w] = '0;
		end
		for (int n = 0; n < 20; n++) begin
			@(negedge clock);
			if (!reset) break;
		end
		if (reset) begin
			$display("reset was never released by the clock generator");
			$display("Simulation failed");
			$fatal(1);
		end else begin
			test_reset_empty();
			test_write_then_read();
			test_forwarding();
			test_eviction();
			test_read_updates_plru();
			test_write_hit_update();
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: list.f
logic/cache_pkg.sv
logic/tag_lookup_if.sv
logic/way_match.sv
logic/plru_tree.sv
logic/cachemem.sv
tb/clock_gen.sv
tb/cachemem_tb.sv

// File: Bender.yml
package:
  name: cachemem

sources:
  - logic/cache_pkg.sv
  - logic/tag_lookup_if.sv
  - logic/way_match.sv
  - logic/plru_tree.sv
  - logic/cachemem.sv
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/cachemem_tb.sv
